// File: mem2axi.f
+incdir+include
source/axi_pkg.sv
source/mem2axi_pkg.sv
source/read_ctrl.sv
source/read_assembler.sv
source/write_ctrl.sv
source/mem2axi.sv
sim/axi_mem_model.sv
sim/tb_mem2axi.sv

// File: sim/tb_mem2axi.sv
// ==========================================================
// testbench for mem2axi, random AXI stalls, checks by assertions
// ==========================================================
`include "mem2axi_defines.svh"

module tb_mem2axi;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TEST_BEATS      = 23;   // read and write beats over all tests
    localparam int CYCLES_PER_BEAT = 32;
    localparam int MAX_CYCLES      = TEST_BEATS * CYCLES_PER_BEAT + 200;

    logic clk, rst_n;
    logic ir_req_i, ire_valid_o, ir_rdy_o, iw_req_i, iw_rdy_o;
    logic [5:0] ir_type_i, iw_type_i;
    logic [31:0] ir_addr_i, iw_addr_i, iw_strb_i;
    logic [255:0] iw_data_i, ire_data_o;
    axi_pkg::axi_ar_t ar_o;
    axi_pkg::axi_r_t r_i;
    axi_pkg::axi_aw_t aw_o;
    axi_pkg::axi_w_t w_o;
    logic ar_valid_o, ar_ready_i, r_valid_i, r_ready_o, b_ready_o;
    logic aw_valid_o, aw_ready_i, w_valid_o, w_ready_i;
    logic [3:0] go;
    logic [15:0] lfsr_q;
    logic [31:0] shadow [0:255];           // expected memory contents
    logic [31:0] rd_base, wr_base, wr_strb;
    logic [255:0] exp_rd_data, wr_data;
    axi_pkg::axi_size_e exp_wsize;
    int ar_seen, aw_seen, w_seen, errors, passed, failed, cycles, e0;

    mem2axi dut0 (.*);

    axi_mem_model mem0 (
        .clk(clk), .ar_i(ar_o), .ar_valid_i(ar_valid_o), .ar_ready_o(ar_ready_i),
        .r_o(r_i), .r_valid_o(r_valid_i), .r_ready_i(r_ready_o),
        .aw_i(aw_o), .aw_valid_i(aw_valid_o), .aw_ready_o(aw_ready_i),
        .w_i(w_o), .w_valid_i(w_valid_o), .w_ready_o(w_ready_i), .go_i(go)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    function automatic int beats_of(logic [5:0] code);
        return (int'(code) + 4) / 4;       // one beat per started word
    endfunction

    function automatic logic [31:0] fill_word(int i);
        return (i * 32'h9e3779b1) ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [255:0] expect_read(logic [31:0] addr, int beats);
        logic [255:0] acc;
        acc = '0;
        for (int k = 0; k < beats; k++)
            acc[k*32 +: 32] = shadow[(addr[9:2] + k) % 256];
        return acc >> (8 * addr[1:0]);
    endfunction

    always @(negedge clk) begin : stall_gen
        logic [31:0] bits;
        draw_bits(4, bits);
        go = bits[3:0];
    end

    // beat counters restart when a request is accepted
    always @(posedge clk) begin
        if (ir_req_i && ir_rdy_o) ar_seen <= 0;
        else if (ar_valid_o && ar_ready_i) ar_seen <= ar_seen + 1;
        if (iw_req_i && iw_rdy_o) begin
            aw_seen <= 0;
            w_seen  <= 0;
        end else begin
            if (aw_valid_o && aw_ready_i) aw_seen <= aw_seen + 1;
            if (w_valid_o && w_ready_i) w_seen <= w_seen + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, a request never completed", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    a_reset: assert property (@(posedge clk) $rose(rst_n) |-> ir_rdy_o && iw_rdy_o
            && !ar_valid_o && !r_ready_o && !aw_valid_o && !w_valid_o && !ire_valid_o)
        else begin
            errors++;
            $display("outputs were not idle after reset");
        end
    a_rd_start: assert property (@(posedge clk) disable iff (!rst_n)
            ir_req_i && ir_rdy_o |=> ar_valid_o ##1 r_ready_o)
        else begin
            errors++;
            $display("read channels did not open in the cycles after the request");
        end
    a_r_open: assert property (@(posedge clk) disable iff (!rst_n)
            r_ready_o && !ire_valid_o |=> r_ready_o)
        else begin
            errors++;
            $display("r_ready_o dropped before the final R beat");
        end
    a_ar_addr: assert property (@(posedge clk) disable iff (!rst_n)
            ar_valid_o && ar_ready_i |-> ar_o.addr == rd_base + 4 * ar_seen)
        else begin
            errors++;
            $display("mismatch ar_o.addr exp %h got %h", $sampled(rd_base + 4 * ar_seen),
                     $sampled(ar_o.addr));
        end
    a_ar_fixed: assert property (@(posedge clk) disable iff (!rst_n)
            ar_valid_o |-> ar_o.size == axi_pkg::SIZE_4B && ar_o.len == 0 && ar_o.id == 0
            && ar_o.burst == axi_pkg::BURST_INCR)
        else begin
            errors++;
            $display("mismatch ar_o fields got %h", $sampled(ar_o));
        end
    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
            ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
        else begin
            errors++;
            $display("AR beat changed while stalled");
        end
    a_rd_data: assert property (@(posedge clk) disable iff (!rst_n)
            ire_valid_o |-> ire_data_o == exp_rd_data)
        else begin
            errors++;
            $display("mismatch ire_data_o exp %h got %h", $sampled(exp_rd_data),
                     $sampled(ire_data_o));
        end
    a_rd_end: assert property (@(posedge clk) disable iff (!rst_n)
            ire_valid_o |=> ir_rdy_o && !ire_valid_o)
        else begin
            errors++;
            $display("read did not end after the result pulse");
        end
    a_wr_start: assert property (@(posedge clk) disable iff (!rst_n)
            iw_req_i && iw_rdy_o |=> aw_valid_o && w_valid_o)
        else begin
            errors++;
            $display("write channels did not open one cycle after the request");
        end
    a_aw: assert property (@(posedge clk) disable iff (!rst_n) aw_valid_o && aw_ready_i
            |-> aw_o.addr == wr_base + 4 * aw_seen && aw_o.size == exp_wsize)
        else begin
            errors++;
            $display("mismatch aw_o exp addr %h size %h got %h", $sampled(wr_base + 4 * aw_seen),
                     $sampled(exp_wsize), $sampled(aw_o));
        end
    a_aw_fixed: assert property (@(posedge clk) disable iff (!rst_n)
            aw_valid_o |-> aw_o.len == 0 && aw_o.id == 0 && aw_o.burst == axi_pkg::BURST_INCR)
        else begin
            errors++;
            $display("mismatch aw_o fields got %h", $sampled(aw_o));
        end
    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
            aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
        else begin
            errors++;
            $display("AW beat changed while stalled");
        end
    a_w: assert property (@(posedge clk) disable iff (!rst_n) w_valid_o && w_ready_i
            |-> w_o.data == wr_data[w_seen*32 +: 32] && w_o.strb == wr_strb[w_seen*4 +: 4]
            && w_o.last)
        else begin
            errors++;
            $display("mismatch w_o exp data %h strb %h got %h",
                     $sampled(wr_data[w_seen*32 +: 32]), $sampled(wr_strb[w_seen*4 +: 4]),
                     $sampled(w_o));
        end
    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
            w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o))
        else begin
            errors++;
            $display("W beat changed while stalled");
        end
    a_b_ready: assert property (@(posedge clk) disable iff (!rst_n) b_ready_o)
        else begin
            errors++;
            $display("mismatch b_ready_o exp 1 got %h", $sampled(b_ready_o));
        end

    task automatic send_read(input logic [5:0] code, input logic [31:0] addr);
        @(negedge clk);
        while (!ir_rdy_o) @(negedge clk);
        rd_base     = addr;
        exp_rd_data = expect_read(addr, beats_of(code));
        ir_type_i   = code;
        ir_addr_i   = addr;
        ir_req_i    = 1'b1;
        @(negedge clk);
        ir_req_i = 1'b0;
        @(posedge clk);
        while (!ire_valid_o) @(posedge clk);
        @(negedge clk);
        assert (mem0.ar_log.size() == beats_of(code)) else begin
            errors++;
            $display("mismatch AR beat count exp %h got %h", beats_of(code),
                     mem0.ar_log.size());
        end
        mem0.ar_log.delete();
    endtask

    task automatic send_write(input logic [5:0] code, input logic [31:0] addr,
                              input logic [255:0] data, input logic [31:0] strb);
        int idx;
        @(negedge clk);
        while (!iw_rdy_o) @(negedge clk);
        wr_base   = addr;
        wr_data   = data;
        wr_strb   = strb;
        exp_wsize = (code == 6'h00) ? axi_pkg::SIZE_1B :
                    (code == 6'h01) ? axi_pkg::SIZE_2B : axi_pkg::SIZE_4B;
        {iw_type_i, iw_addr_i, iw_data_i, iw_strb_i} = {code, addr, data, strb};
        iw_req_i = 1'b1;
        @(negedge clk);
        iw_req_i = 1'b0;
        while (!iw_rdy_o) @(negedge clk);
        for (int k = 0; k < beats_of(code); k++) begin
            idx = (addr[9:2] + k) % 256;
            for (int b = 0; b < 4; b++)
                if (strb[k*4 + b]) shadow[idx][b*8 +: 8] = data[k*32 + b*8 +: 8];
            assert (mem0.mem[idx] === shadow[idx]) else begin
                errors++;
                $display("mismatch mem[%h] exp %h got %h", idx, shadow[idx], mem0.mem[idx]);
            end
        end
        assert (mem0.aw_log.size() == beats_of(code)) else begin
            errors++;
            $display("mismatch AW beat count exp %h got %h", beats_of(code),
                     mem0.aw_log.size());
        end
        mem0.aw_log.delete();
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            passed++;
            $display("test %s: pass", name);
        end else begin
            failed++;
            $display("test %s: FAIL", name);
        end
    endtask

    task automatic random_wide(output logic [255:0] v);
        logic [31:0] part;
        for (int k = 0; k < 8; k++) begin
            draw_bits(32, part);
            v[k*32 +: 32] = part;
        end
    endtask

    initial begin : main
        logic [255:0] data;
        logic [31:0]  strb;
        rst_n = 1'b0;
        {ir_req_i, iw_req_i, ir_type_i, iw_type_i, ir_addr_i, iw_addr_i} = '0;
        {iw_strb_i, iw_data_i, go} = '0;
        lfsr_q = 16'd29401;
        for (int i = 0; i < 256; i++) begin
            shadow[i]   = fill_word(i);
            mem0.mem[i] = fill_word(i);
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        end_test("reset", 0);
        e0 = errors;
        send_read(6'h03, 32'h40);
        end_test("read 4 bytes", e0);
        e0 = errors;
        send_read(6'h1f, 32'h80);
        end_test("read 32 bytes", e0);
        e0 = errors;
        send_read(6'h00, 32'hc3);
        send_read(6'h01, 32'hd2);
        end_test("sub-word reads", e0);
        e0 = errors;
        random_wide(data);
        draw_bits(32, strb);
        send_write(6'h1f, 32'h200, data, strb);
        end_test("write 32 bytes", e0);
        e0 = errors;
        random_wide(data);
        send_write(6'h07, 32'h300, data, '1);
        send_read(6'h07, 32'h300);
        end_test("write then read", e0);
        @(negedge clk);
        $display("tests passed %0d, failed %0d, check failures %0d", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sim/axi_mem_model.sv
// ==========================================================
// AXI slave memory of 256 words, ready and valid gated by go_i
// ==========================================================
`include "mem2axi_defines.svh"

module axi_mem_model (
    input  logic              clk,
    input  axi_pkg::axi_ar_t  ar_i,
    input  logic              ar_valid_i,
    output logic              ar_ready_o,
    output axi_pkg::axi_r_t   r_o,
    output logic              r_valid_o,
    input  logic              r_ready_i,
    input  axi_pkg::axi_aw_t  aw_i,
    input  logic              aw_valid_i,
    output logic              aw_ready_o,
    input  axi_pkg::axi_w_t   w_i,
    input  logic              w_valid_i,
    output logic              w_ready_o,
    input  logic [3:0]        go_i      // ar, r, aw, w enables from the LFSR
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`AXI_DATA_W-1:0] mem [0:255];
    logic [31:0]            rd_q [$];   // read addresses waiting for R
    logic [31:0]            aw_q [$];
    axi_pkg::axi_w_t        w_q [$];
    axi_pkg::axi_ar_t       ar_log [$];
    axi_pkg::axi_aw_t       aw_log [$];
    logic [3:0]             ready_nxt;
    logic                   r_valid_nxt;
    logic [`AXI_DATA_W-1:0] r_data_nxt;

    initial begin
        ar_ready_o  = 1'b0;
        aw_ready_o  = 1'b0;
        w_ready_o   = 1'b0;
        r_valid_o   = 1'b0;
        r_o         = '0;
        ready_nxt   = '0;
        r_valid_nxt = 1'b0;
        r_data_nxt  = '0;
    end

    // handshakes are seen on the rising edge
    always @(posedge clk) begin
        logic [31:0]     addr;
        axi_pkg::axi_w_t w;
        if (ar_valid_i && ar_ready_o) begin
            rd_q.push_back(ar_i.addr);
            ar_log.push_back(ar_i);
        end
        if (r_valid_o && r_ready_i) begin
            void'(rd_q.pop_front());
            r_valid_nxt = 1'b0;
        end
        if (aw_valid_i && aw_ready_o) begin
            aw_q.push_back(aw_i.addr);
            aw_log.push_back(aw_i);
        end
        if (w_valid_i && w_ready_o)
            w_q.push_back(w_i);
        while (aw_q.size() > 0 && w_q.size() > 0) begin
            addr = aw_q.pop_front();
            w    = w_q.pop_front();
            for (int b = 0; b < 4; b++) begin
                if (w.strb[b])
                    mem[addr[9:2]][b*8 +: 8] = w.data[b*8 +: 8];
            end
        end
        if (!r_valid_nxt && rd_q.size() > 0 && go_i[1]) begin
            r_valid_nxt = 1'b1;
            r_data_nxt  = mem[rd_q[0][9:2]];
        end
        ready_nxt = go_i;
    end

    // outputs change on the falling edge only
    always @(negedge clk) begin
        ar_ready_o = ready_nxt[0];
        aw_ready_o = ready_nxt[2];
        w_ready_o  = ready_nxt[3];
        r_valid_o  = r_valid_nxt;
        r_o        = '{id: '0, data: r_data_nxt, resp: 2'b00, last: 1'b1};
    end

endmodule

// File: source/mem2axi.sv
// ==========================================================
// memory bus to AXI adapter top, one read and one write in flight
// requests are captured on req & rdy and split into 32-bit beats
// ==========================================================
`include "mem2axi_defines.svh"

module mem2axi (
    input  logic                   clk,
    input  logic                   rst_n,
    // read request and result
    input  logic                   ir_req_i,
    input  logic [`MEM_TYPE_W-1:0] ir_type_i,
    input  logic [`MEM_ADDR_W-1:0] ir_addr_i,
    output logic                   ir_rdy_o,
    output logic [`MEM_DATA_W-1:0] ire_data_o,
    output logic                   ire_valid_o,
    // write request
    input  logic                   iw_req_i,
    input  logic [`MEM_TYPE_W-1:0] iw_type_i,
    input  logic [`MEM_ADDR_W-1:0] iw_addr_i,
    input  logic [`MEM_STRB_W-1:0] iw_strb_i,
    input  logic [`MEM_DATA_W-1:0] iw_data_i,
    output logic                   iw_rdy_o,
    // AXI master
    output axi_pkg::axi_ar_t       ar_o,
    output logic                   ar_valid_o,
    input  logic                   ar_ready_i,
    input  axi_pkg::axi_r_t        r_i,
    input  logic                   r_valid_i,
    output logic                   r_ready_o,
    output axi_pkg::axi_aw_t       aw_o,
    output logic                   aw_valid_o,
    input  logic                   aw_ready_i,
    output axi_pkg::axi_w_t        w_o,
    output logic                   w_valid_o,
    input  logic                   w_ready_i,
    output logic                   b_ready_o
);

    mem2axi_pkg::mem_rd_req_t rd_req_q;
    mem2axi_pkg::mem_wr_req_t wr_req_q;
    logic                     rd_start;
    logic                     wr_start;
    logic [`BEAT_CNT_W-1:0]   r_beat;
    logic                     r_accept;
    logic                     r_done;

    assign rd_start = ir_req_i & ir_rdy_o;
    assign wr_start = iw_req_i & iw_rdy_o;

    // request registers, held for the whole transfer
    always_ff @(posedge clk) begin
        if (rd_start) begin
            rd_req_q.size_code <= mem2axi_pkg::size_code_e'(ir_type_i);
            rd_req_q.addr      <= ir_addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_start) begin
            wr_req_q.size_code <= mem2axi_pkg::size_code_e'(iw_type_i);
            wr_req_q.addr      <= iw_addr_i;
            wr_req_q.strb      <= iw_strb_i;
            wr_req_q.data      <= iw_data_i;
        end
    end

    read_ctrl u_read_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (rd_start),
        .req_i      (rd_req_q),
        .ar_o       (ar_o),
        .ar_valid_o (ar_valid_o),
        .ar_ready_i (ar_ready_i),
        .r_valid_i  (r_valid_i),
        .r_ready_o  (r_ready_o),
        .rdy_o      (ir_rdy_o),
        .r_beat_o   (r_beat),
        .r_accept_o (r_accept),
        .r_done_o   (r_done)
    );

    read_assembler u_read_assembler (
        .clk        (clk),
        .rst_n      (rst_n),
        .r_data_i   (r_i.data),
        .r_beat_i   (r_beat),
        .r_accept_i (r_accept),
        .r_done_i   (r_done),
        .lane_i     (rd_req_q.addr[1:0]),
        .data_o     (ire_data_o)
    );

    assign ire_valid_o = r_done;     // same cycle as the final R handshake

    write_ctrl u_write_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (wr_start),
        .req_i      (wr_req_q),
        .aw_o       (aw_o),
        .aw_valid_o (aw_valid_o),
        .aw_ready_i (aw_ready_i),
        .w_o        (w_o),
        .w_valid_o  (w_valid_o),
        .w_ready_i  (w_ready_i),
        .rdy_o      (iw_rdy_o)
    );

    assign b_ready_o = 1'b1;         // write responses are not tracked

endmodule

// File: source/write_ctrl.sv
// ==========================================================
// write sequencer, drives AW and W beats for one request
// AW and W run on their own counters, iw_rdy waits for both
// ==========================================================
`include "mem2axi_defines.svh"

module write_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start_i,
    input  mem2axi_pkg::mem_wr_req_t req_i,
    output axi_pkg::axi_aw_t         aw_o,
    output logic                     aw_valid_o,
    input  logic                     aw_ready_i,
    output axi_pkg::axi_w_t          w_o,
    output logic                     w_valid_o,
    input  logic                     w_ready_i,
    output logic                     rdy_o
);

    mem2axi_pkg::wr_state_e state_q;
    mem2axi_pkg::wr_state_e state_d;
    logic [`BEAT_CNT_W-1:0] last_beat;
    logic [`BEAT_CNT_W-1:0] aw_cnt_q;
    logic [`BEAT_CNT_W-1:0] w_cnt_q;
    logic                   w_fin_q;       // W side already done
    logic                   aw_fire;
    logic                   w_fire;
    logic                   aw_last;
    logic                   w_last;
    logic [`MEM_ADDR_W-1:0] aw_offset;
    axi_pkg::axi_size_e     aw_size;

    assign last_beat = mem2axi_pkg::last_beat_of(req_i.size_code);

    assign aw_valid_o = (state_q == mem2axi_pkg::WR_ADDR_DATA);
    assign w_valid_o  = (state_q != mem2axi_pkg::WR_IDLE) & ~w_fin_q;

    assign aw_fire = aw_valid_o & aw_ready_i;
    assign w_fire  = w_valid_o & w_ready_i;
    assign aw_last = aw_fire & (aw_cnt_q == last_beat);
    assign w_last  = w_fire & (w_cnt_q == last_beat);

    assign rdy_o = (state_q == mem2axi_pkg::WR_IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem2axi_pkg::WR_IDLE: begin
                if (start_i) begin
                    state_d = mem2axi_pkg::WR_ADDR_DATA;
                end
            end
            mem2axi_pkg::WR_ADDR_DATA: begin
                if (aw_last) begin
                    // W may have finished earlier or on this same cycle
                    if (w_last || w_fin_q) begin
                        state_d = mem2axi_pkg::WR_IDLE;
                    end else begin
                        state_d = mem2axi_pkg::WR_DATA_ONLY;
                    end
                end
            end
            mem2axi_pkg::WR_DATA_ONLY: begin
                if (w_last) begin
                    state_d = mem2axi_pkg::WR_IDLE;
                end
            end
            default: state_d = mem2axi_pkg::WR_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= mem2axi_pkg::WR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_fin_q <= 1'b0;
        end else if (state_q == mem2axi_pkg::WR_IDLE) begin
            w_fin_q <= 1'b0;
        end else if (w_last) begin
            w_fin_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            aw_cnt_q <= '0;
        end else if (state_q == mem2axi_pkg::WR_IDLE) begin
            aw_cnt_q <= '0;
        end else if (aw_fire) begin
            aw_cnt_q <= aw_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_cnt_q <= '0;
        end else if (state_q == mem2axi_pkg::WR_IDLE) begin
            w_cnt_q <= '0;
        end else if (w_fire) begin
            w_cnt_q <= w_cnt_q + 1'b1;
        end
    end

    // sub-word codes keep their own size, everything else goes as words
    always_comb begin
        case (req_i.size_code)
            mem2axi_pkg::CODE_1B: aw_size = axi_pkg::SIZE_1B;
            mem2axi_pkg::CODE_2B: aw_size = axi_pkg::SIZE_2B;
            default:              aw_size = axi_pkg::SIZE_4B;
        endcase
    end

    assign aw_offset = {{(`MEM_ADDR_W - `BEAT_CNT_W - 2){1'b0}}, aw_cnt_q, 2'b00};

    assign aw_o = '{
        addr:  req_i.addr + aw_offset,
        id:    '0,
        len:   '0,
        size:  aw_size,
        burst: axi_pkg::BURST_INCR
    };

    // every W beat is a single-beat transaction, so last is always set
    assign w_o = '{
        data: req_i.data[w_cnt_q * `AXI_DATA_W +: `AXI_DATA_W],
        strb: req_i.strb[w_cnt_q * `AXI_STRB_W +: `AXI_STRB_W],
        last: 1'b1
    };

endmodule

// File: source/read_assembler.sv
// ==========================================================
// collects R words into the wide read result
// output is valid in the cycle of the final R handshake
// ==========================================================
`include "mem2axi_defines.svh"

module read_assembler (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`AXI_DATA_W-1:0] r_data_i,
    input  logic [`BEAT_CNT_W-1:0] r_beat_i,
    input  logic                   r_accept_i,
    input  logic                   r_done_i,
    input  logic [1:0]             lane_i,
    output logic [`MEM_DATA_W-1:0] data_o
);

    logic [`MEM_DATA_W-1:0] acc_q;     // words gathered so far
    logic [`MEM_DATA_W-1:0] merged;

    // current beat goes straight into its slice so the last word needs no extra cycle
    always_comb begin
        merged = acc_q;
        if (r_accept_i) begin
            merged[r_beat_i * `AXI_DATA_W +: `AXI_DATA_W] = r_data_i;
        end
    end

    // sub-word reads land at byte lane addr[1:0]
    assign data_o = merged >> {lane_i, 3'b000};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (r_done_i) begin
            acc_q <= '0;                  // ready for the next read
        end else if (r_accept_i) begin
            acc_q <= merged;
        end
    end

endmodule

// File: source/read_ctrl.sv
// ==========================================================
// read sequencer, issues one AR per word and counts R beats
// ir_rdy comes from here, the final R handshake closes a read
// ==========================================================
`include "mem2axi_defines.svh"

module read_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start_i,
    input  mem2axi_pkg::mem_rd_req_t req_i,
    output axi_pkg::axi_ar_t         ar_o,
    output logic                     ar_valid_o,
    input  logic                     ar_ready_i,
    input  logic                     r_valid_i,
    output logic                     r_ready_o,
    output logic                     rdy_o,
    output logic [`BEAT_CNT_W-1:0]   r_beat_o,
    output logic                     r_accept_o,
    output logic                     r_done_o
);

    mem2axi_pkg::rd_state_e state_q;
    mem2axi_pkg::rd_state_e state_d;
    logic                   r_open_q;      // R collection window
    logic [`BEAT_CNT_W-1:0] last_beat;
    logic [`BEAT_CNT_W-1:0] ar_cnt_q;
    logic [`BEAT_CNT_W-1:0] r_cnt_q;
    logic [`MEM_ADDR_W-1:0] ar_offset;
    logic                   ar_fire;
    logic                   ar_last;

    assign last_beat = mem2axi_pkg::last_beat_of(req_i.size_code);

    assign ar_valid_o = (state_q == mem2axi_pkg::RD_ADDR);
    assign ar_fire    = ar_valid_o & ar_ready_i;
    assign ar_last    = ar_fire & (ar_cnt_q == last_beat);

    assign r_ready_o  = r_open_q;
    assign r_accept_o = r_open_q & r_valid_i;
    assign r_done_o   = r_accept_o & (r_cnt_q == last_beat);
    assign r_beat_o   = r_cnt_q;

    assign rdy_o = (state_q == mem2axi_pkg::RD_IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem2axi_pkg::RD_IDLE: begin
                if (start_i) begin
                    state_d = mem2axi_pkg::RD_ADDR;
                end
            end
            mem2axi_pkg::RD_ADDR: begin
                if (ar_last) begin
                    state_d = mem2axi_pkg::RD_DATA;   // all addresses out
                end
            end
            mem2axi_pkg::RD_DATA: begin
                if (r_done_o) begin
                    state_d = mem2axi_pkg::RD_IDLE;
                end
            end
            default: state_d = mem2axi_pkg::RD_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= mem2axi_pkg::RD_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // opens one cycle after AR starts and stays open across the AR issue
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_open_q <= 1'b0;
        end else if (r_done_o) begin
            r_open_q <= 1'b0;
        end else if (state_q == mem2axi_pkg::RD_ADDR) begin
            r_open_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ar_cnt_q <= '0;
        end else if (state_q != mem2axi_pkg::RD_ADDR) begin
            ar_cnt_q <= '0;
        end else if (ar_fire) begin
            ar_cnt_q <= ar_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_cnt_q <= '0;
        end else if (r_done_o || !r_open_q) begin
            r_cnt_q <= '0;
        end else if (r_accept_o) begin
            r_cnt_q <= r_cnt_q + 1'b1;
        end
    end

    // word k sits at base + 4k
    assign ar_offset = {{(`MEM_ADDR_W - `BEAT_CNT_W - 2){1'b0}}, ar_cnt_q, 2'b00};

    assign ar_o = '{
        addr:  req_i.addr + ar_offset,
        id:    '0,
        len:   '0,
        size:  axi_pkg::SIZE_4B,
        burst: axi_pkg::BURST_INCR
    };

endmodule

// File: source/mem2axi_pkg.sv
// ==========================================================
// memory-bus request types, size codes and controller states
// ==========================================================
`include "mem2axi_defines.svh"

package mem2axi_pkg;

    // request length in bytes, coded as bytes minus one
    typedef enum logic [`MEM_TYPE_W-1:0] {
        CODE_1B  = 6'h00,
        CODE_2B  = 6'h01,
        CODE_4B  = 6'h03,
        CODE_8B  = 6'h07,
        CODE_16B = 6'h0f,
        CODE_32B = 6'h1f
    } size_code_e;

    typedef struct packed {
        size_code_e             size_code;
        logic [`MEM_ADDR_W-1:0] addr;
    } mem_rd_req_t;

    typedef struct packed {
        size_code_e             size_code;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_STRB_W-1:0] strb;
        logic [`MEM_DATA_W-1:0] data;
    } mem_wr_req_t;

    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;

    typedef enum logic [1:0] {WR_IDLE, WR_ADDR_DATA, WR_DATA_ONLY} wr_state_e;

    // index of the final 32-bit beat, one beat per started word
    function automatic logic [`BEAT_CNT_W-1:0] last_beat_of(size_code_e code);
        logic [`BEAT_CNT_W-1:0] idx;
        case (code)
            CODE_8B:  idx = `BEAT_CNT_W'(1);
            CODE_16B: idx = `BEAT_CNT_W'(3);
            CODE_32B: idx = `BEAT_CNT_W'(7);
            default:  idx = '0;   // 1, 2 and 4 bytes fit in one beat
        endcase
        return idx;
    endfunction

endpackage

// File: source/axi_pkg.sv
// ==========================================================
// AXI channel payload types and encodings for the adapter
// ==========================================================
`include "mem2axi_defines.svh"

package axi_pkg;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01
    } axi_burst_e;

    // bytes per beat, log2 coded
    typedef enum logic [2:0] {
        SIZE_1B = 3'b000,
        SIZE_2B = 3'b001,
        SIZE_4B = 3'b010
    } axi_size_e;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_LEN_W-1:0]  len;   // beats minus one
        axi_size_e              size;
        axi_burst_e             burst;
    } axi_ar_t;

    // write address carries the same fields as read address
    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
        logic [1:0]             resp;
        logic                   last;
    } axi_r_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_STRB_W-1:0] strb;
        logic                   last;
    } axi_w_t;

endpackage

// File: include/mem2axi_defines.svh
// ==========================================================
// width and count macros shared by the mem2axi packages and RTL
// include wherever a bus or counter width is needed
// ==========================================================
`ifndef MEM2AXI_DEFINES_SVH
`define MEM2AXI_DEFINES_SVH

// memory side
`define MEM_ADDR_W   32
`define MEM_DATA_W   256
`define MEM_STRB_W   32   // one bit per byte of MEM_DATA_W
`define MEM_TYPE_W   6    // size code, bytes minus one

// AXI side, single 32-bit beats
`define AXI_DATA_W   32
`define AXI_STRB_W   4
`define AXI_ID_W     4
`define AXI_LEN_W    8

// beat index within one request, up to 8 words of 32 bits
`define BEAT_CNT_W   3

`endif // MEM2AXI_DEFINES_SVH
